// ==== include/lmx_config.svh ====
// Memory, MMIO, read credit and ID configuration macros for the memory exerciser
`ifndef LMX_CONFIG_SVH
`define LMX_CONFIG_SVH

// Local memory word address width
`define LMX_MEM_ADDR_W 16

// MMIO register index width for eight 64-bit registers
`define LMX_MMIO_ADDR_W 3

// Reads allowed in flight on the local memory port
`define LMX_MAX_RD_OUTSTANDING 8

// Value of the ID register
`define LMX_ID_VALUE 64'h4C4D_5845_5243_0001

`endif

// ==== tb/lmx_mem_model.sv ====
// Avalon-MM slave memory model with random waitrequest, in-order read latency and backdoor tasks
`timescale 1ns/1ps
`include "lmx_config.svh"

// Simulation bank of 4096 words
// The package is compiled after this file and picks up the narrower width
`undef LMX_MEM_ADDR_W
`define LMX_MEM_ADDR_W 12

module lmx_mem_model
#(
    parameter int SEED = 1
)
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`LMX_MEM_ADDR_W-1:0] address,
    input  logic                       read,
    input  logic                       write,
    input  logic [63:0]                writedata,
    output logic                       waitrequest,
    output logic                       readdatavalid,
    output logic [63:0]                readdata
);

    localparam int WORDS = 1 << `LMX_MEM_ADDR_W;

    logic [63:0] mem [WORDS];

    // Pending read data and the cycle each word is due
    logic [63:0] data_q [$];
    longint      due_q [$];
    longint      cycle;
    longint      last_due;

    // Timing knobs set by the testbench between runs
    int wait_pct = 0;
    int lat_min  = 1;
    int lat_max  = 1;

    // Request statistics
    int rd_count      = 0;
    int wr_count      = 0;
    int in_flight     = 0;
    int max_in_flight = 0;

    // ==================================================
    // Slave process
    // ==================================================
    initial
    begin
        longint due;
        int     lat;
        void'($urandom(SEED));
        // Fill pattern built from the whole word address
        for (int i = 0; i < WORDS; i++)
        begin
            mem[i] = {32'(i) ^ 32'hC3A5_5A3C, ~32'(i)};
        end
        waitrequest   = 1'b0;
        readdatavalid = 1'b0;
        readdata      = '0;
        cycle         = 0;
        last_due      = 0;
        forever
        begin
            @(posedge clk);
            if (rst)
            begin
                waitrequest   <= 1'b0;
                readdatavalid <= 1'b0;
                readdata      <= '0;
                data_q.delete();
                due_q.delete();
                cycle     = 0;
                last_due  = 0;
                in_flight = 0;
            end
            else
            begin
                cycle++;
                // Accepted read takes its data now and returns it in order
                if (read && !waitrequest)
                begin
                    lat = $urandom_range(lat_max, lat_min);
                    due = cycle + lat;
                    if (due <= last_due)
                    begin
                        due = last_due + 1;
                    end
                    last_due = due;
                    data_q.push_back(mem[address]);
                    due_q.push_back(due);
                    rd_count++;
                    in_flight++;
                    if (in_flight > max_in_flight)
                    begin
                        max_in_flight = in_flight;
                    end
                end
                if (write && !waitrequest)
                begin
                    mem[address] = writedata;
                    wr_count++;
                end
                readdatavalid <= 1'b0;
                if (due_q.size() != 0 && due_q[0] == cycle)
                begin
                    readdatavalid <= 1'b1;
                    readdata      <= data_q.pop_front();
                    void'(due_q.pop_front());
                    in_flight--;
                end
                waitrequest <= ($urandom_range(99) < wait_pct);
            end
        end
    end

    // ==================================================
    // Backdoor access
    // ==================================================
    task automatic set_timing(input int wpct, input int lmin, input int lmax);
        wait_pct = wpct;
        lat_min  = lmin;
        lat_max  = lmax;
    endtask

    // Peak restarts from what is in flight now
    task automatic reset_peak();
        max_in_flight = in_flight;
    endtask

    function automatic logic [63:0] peek(input logic [`LMX_MEM_ADDR_W-1:0] addr);
        return mem[addr];
    endfunction

    // Any nonzero flip gives a mismatch
    task automatic corrupt_word(input logic [`LMX_MEM_ADDR_W-1:0] addr);
        mem[addr] = mem[addr] ^ 64'h0000_0100_0000_8001;
    endtask

endmodule

// ==== hdl/lmx_pkg.sv ====
// Shared vector types, bus structs, run configuration and control FSM state
`include "lmx_config.svh"

package lmx_pkg;

    // ==================================================
    // Vector types
    // ==================================================
    typedef logic [`LMX_MEM_ADDR_W-1:0]  t_mem_addr;
    typedef logic [63:0]                 t_mem_data;
    typedef logic [`LMX_MMIO_ADDR_W-1:0] t_mmio_addr;
    // One extra bit so a full bank fits
    typedef logic [`LMX_MEM_ADDR_W:0]    t_word_count;

    // ==================================================
    // Local memory Avalon-MM master side
    // ==================================================
    typedef struct packed {
        t_mem_addr address;
        logic      read;
        logic      write;
        t_mem_data writedata;
    } t_mem_req;

    typedef struct packed {
        logic      waitrequest;
        logic      readdatavalid;
        t_mem_data readdata;
    } t_mem_rsp;

    // ==================================================
    // MMIO slave side
    // ==================================================
    typedef struct packed {
        t_mmio_addr address;
        logic       read;
        logic       write;
        t_mem_data  writedata;
    } t_mmio_req;

    typedef struct packed {
        logic      readdatavalid;
        t_mem_data readdata;
    } t_mmio_rsp;

    // Run setup handed to the datapath
    // mode is 1 for read-only
    typedef struct packed {
        t_mem_addr   base;
        t_word_count count;
        logic        mode;
    } t_run_cfg;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ,
        DONE
    } t_ctl_state;

endpackage

// ==== hdl/lmx_pattern_gen.sv ====
// Galois LFSR data pattern generator, one 64-bit word per step
`timescale 1ns/1ps

module lmx_pattern_gen
(
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  lmx_pkg::t_mem_data seed,
    input  logic               advance,
    output lmx_pkg::t_mem_data word
);

    // x^64 + x^63 + x^61 + x^60 + 1, right shifting form
    // Exponent k maps to mask bit k-1
    localparam lmx_pkg::t_mem_data TAPS = 64'hD800_0000_0000_0000;

    lmx_pkg::t_mem_data state;
    lmx_pkg::t_mem_data next_state;

    // Feedback from the bit shifted out
    always_comb
    begin
        next_state = state >> 1;
        if (state[0])
        begin
            next_state = next_state ^ TAPS;
        end
    end

    // Load wins over advance
    // An all-zero seed stays at zero
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= '0;
        end
        else if (load)
        begin
            state <= seed;
        end
        else if (advance)
        begin
            state <= next_state;
        end
    end

    // Current state is the word for the current index
    assign word = state;

endmodule

// ==== hdl/lmx_mem_engine.sv ====
// Avalon-MM master issuing the write phase and the credit limited read phase
`timescale 1ns/1ps
`include "lmx_config.svh"

module lmx_mem_engine
(
    input  logic               clk,
    input  logic               rst,
    input  lmx_pkg::t_run_cfg  cfg,
    input  logic               wr_start,
    input  logic               rd_start,
    input  lmx_pkg::t_mem_data wr_data,
    input  lmx_pkg::t_mem_rsp  mem_rsp,
    output lmx_pkg::t_mem_req  mem_req,
    output logic               wr_advance,
    output logic               wr_done
);

    localparam int MAX_RD = `LMX_MAX_RD_OUTSTANDING;
    localparam int CRED_W = $clog2(MAX_RD + 1);

    logic                 wr_act;
    logic                 rd_act;
    lmx_pkg::t_mem_addr   addr_q;
    lmx_pkg::t_word_count idx_q;
    logic [CRED_W-1:0]    credits;
    logic                 rd_ok;
    logic                 wr_acc;
    logic                 rd_acc;
    logic                 last;

    // Reads held back once the credit limit is reached
    assign rd_ok = (credits != CRED_W'(MAX_RD));

    // ==================================================
    // Request
    // ==================================================
    // Inputs to the request are stable while waitrequest is high
    always_comb
    begin
        mem_req.address   = addr_q;
        mem_req.write     = wr_act;
        mem_req.read      = rd_act && rd_ok;
        mem_req.writedata = wr_data;
    end

    assign wr_acc = mem_req.write && !mem_rsp.waitrequest;
    assign rd_acc = mem_req.read && !mem_rsp.waitrequest;
    assign last   = (idx_q == cfg.count - 1'b1);

    // Each accepted write consumes one pattern word
    assign wr_advance = wr_acc;
    assign wr_done    = wr_acc && last;

    // ==================================================
    // Phase and address tracking
    // ==================================================
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_act <= 1'b0;
            rd_act <= 1'b0;
            addr_q <= '0;
            idx_q  <= '0;
        end
        else if (wr_start || rd_start)
        begin
            // Both phases walk from base
            wr_act <= wr_start;
            rd_act <= rd_start;
            addr_q <= cfg.base;
            idx_q  <= '0;
        end
        else if (wr_acc || rd_acc)
        begin
            addr_q <= addr_q + 1'b1;
            idx_q  <= idx_q + 1'b1;
            if (last)
            begin
                wr_act <= 1'b0;
                rd_act <= 1'b0;
            end
        end
    end

    // Read credits
    // Up on accepted read, down on returned data
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            credits <= '0;
        end
        else
        begin
            case ({rd_acc, mem_rsp.readdatavalid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// ==== hdl/lmx_checker.sv ====
// Read data checker with error count, first failing address and phase end
`timescale 1ns/1ps

module lmx_checker
(
    input  logic                 clk,
    input  logic                 rst,
    input  lmx_pkg::t_run_cfg    cfg,
    input  logic                 rd_start,
    input  lmx_pkg::t_mem_rsp    mem_rsp,
    input  lmx_pkg::t_mem_data   expected,
    output logic                 rd_advance,
    output logic                 rd_done,
    output lmx_pkg::t_word_count err_count,
    output lmx_pkg::t_mem_addr   first_err_addr
);

    logic                 active;
    lmx_pkg::t_word_count idx_q;
    logic                 take;
    logic                 mismatch;

    // Every response is consumed on arrival
    assign take     = active && mem_rsp.readdatavalid;
    assign mismatch = take && (mem_rsp.readdata != expected);

    assign rd_advance = take;
    assign rd_done    = take && (idx_q == cfg.count - 1'b1);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            active         <= 1'b0;
            idx_q          <= '0;
            err_count      <= '0;
            first_err_addr <= '0;
        end
        else if (rd_start)
        begin
            // Fresh read phase
            active         <= 1'b1;
            idx_q          <= '0;
            err_count      <= '0;
            first_err_addr <= '0;
        end
        else if (take)
        begin
            idx_q <= idx_q + 1'b1;
            if (mismatch)
            begin
                err_count <= err_count + 1'b1;
                // Only the first failure keeps its address
                if (err_count == '0)
                begin
                    first_err_addr <= cfg.base + lmx_pkg::t_mem_addr'(idx_q);
                end
            end
            if (rd_done)
            begin
                active <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/lmx_ctl.sv ====
// MMIO register file and run sequencer FSM of the memory exerciser
`timescale 1ns/1ps
`include "lmx_config.svh"

module lmx_ctl
(
    input  logic                clk,
    input  logic                rst,
    input  lmx_pkg::t_mmio_req  mmio_req,
    input  logic                wr_done,
    input  logic                rd_done,
    input  lmx_pkg::t_word_count err_count,
    input  lmx_pkg::t_mem_addr  first_err_addr,
    output lmx_pkg::t_mmio_rsp  mmio_rsp,
    output lmx_pkg::t_run_cfg   cfg,
    output lmx_pkg::t_mem_data  seed,
    output logic                wr_start,
    output logic                rd_start,
    output logic                load_seed
);

    // Register word indices
    localparam lmx_pkg::t_mmio_addr REG_ID        = lmx_pkg::t_mmio_addr'(0);
    localparam lmx_pkg::t_mmio_addr REG_CTRL      = lmx_pkg::t_mmio_addr'(1);
    localparam lmx_pkg::t_mmio_addr REG_BASE      = lmx_pkg::t_mmio_addr'(2);
    localparam lmx_pkg::t_mmio_addr REG_COUNT     = lmx_pkg::t_mmio_addr'(3);
    localparam lmx_pkg::t_mmio_addr REG_SEED      = lmx_pkg::t_mmio_addr'(4);
    localparam lmx_pkg::t_mmio_addr REG_STATUS    = lmx_pkg::t_mmio_addr'(5);
    localparam lmx_pkg::t_mmio_addr REG_ERR_COUNT = lmx_pkg::t_mmio_addr'(6);
    localparam lmx_pkg::t_mmio_addr REG_FIRST_ERR = lmx_pkg::t_mmio_addr'(7);

    lmx_pkg::t_ctl_state state;
    lmx_pkg::t_mem_addr  base_q;
    lmx_pkg::t_word_count count_q;
    lmx_pkg::t_mem_data  seed_q;
    logic                mode_q;
    logic                busy;
    logic                done;
    logic                res_vis;
    logic                start_fire;
    lmx_pkg::t_mem_data  rd_data;

    assign busy = (state == lmx_pkg::WRITE) || (state == lmx_pkg::READ);
    assign done = (state == lmx_pkg::DONE);

    // Checker results belong to this run only once its read phase has begun
    assign res_vis = done || ((state == lmx_pkg::READ) && !rd_start);

    // Start bit on a CTRL write, dropped while a run is active
    assign start_fire = mmio_req.write && (mmio_req.address == REG_CTRL) &&
                        mmio_req.writedata[0] && !busy;

    assign cfg.base  = base_q;
    assign cfg.count = count_q;
    assign cfg.mode  = mode_q;
    assign seed      = seed_q;

    // ==================================================
    // Register writes and sequencer
    // ==================================================
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= lmx_pkg::IDLE;
            base_q    <= '0;
            count_q   <= '0;
            seed_q    <= '0;
            mode_q    <= 1'b0;
            wr_start  <= 1'b0;
            rd_start  <= 1'b0;
            load_seed <= 1'b0;
        end
        else
        begin
            // Start pulses last a single cycle
            wr_start  <= 1'b0;
            rd_start  <= 1'b0;
            load_seed <= 1'b0;

            // Setup registers hold steady for the run in progress
            if (mmio_req.write && !busy)
            begin
                case (mmio_req.address)
                    REG_CTRL:  mode_q  <= mmio_req.writedata[1];
                    REG_BASE:  base_q  <= lmx_pkg::t_mem_addr'(mmio_req.writedata);
                    REG_COUNT: count_q <= lmx_pkg::t_word_count'(mmio_req.writedata);
                    REG_SEED:  seed_q  <= mmio_req.writedata;
                    default:   ;
                endcase
            end

            case (state)
                lmx_pkg::IDLE,
                lmx_pkg::DONE:
                begin
                    if (start_fire)
                    begin
                        load_seed <= 1'b1;
                        if (mmio_req.writedata[1])
                        begin
                            // Read-only skips the write phase
                            state    <= lmx_pkg::READ;
                            rd_start <= 1'b1;
                        end
                        else
                        begin
                            state    <= lmx_pkg::WRITE;
                            wr_start <= 1'b1;
                        end
                    end
                end
                lmx_pkg::WRITE:
                begin
                    if (wr_done)
                    begin
                        state    <= lmx_pkg::READ;
                        rd_start <= 1'b1;
                    end
                end
                lmx_pkg::READ:
                begin
                    if (rd_done)
                    begin
                        state <= lmx_pkg::DONE;
                    end
                end
                default: state <= lmx_pkg::IDLE;
            endcase
        end
    end

    // ==================================================
    // Register reads
    // ==================================================
    always_comb
    begin
        rd_data = '0;
        case (mmio_req.address)
            REG_ID:        rd_data = `LMX_ID_VALUE;
            REG_CTRL:      rd_data = {62'b0, mode_q, 1'b0};
            REG_BASE:      rd_data = 64'(base_q);
            REG_COUNT:     rd_data = 64'(count_q);
            REG_SEED:      rd_data = seed_q;
            REG_STATUS:    rd_data = {61'b0, res_vis && (err_count != '0), done, busy};
            REG_ERR_COUNT: rd_data = res_vis ? 64'(err_count) : '0;
            REG_FIRST_ERR: rd_data = res_vis ? 64'(first_err_addr) : '0;
            default:       rd_data = '0;
        endcase
    end

    // Response valid one cycle after the read
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mmio_rsp.readdatavalid <= 1'b0;
        end
        else
        begin
            mmio_rsp.readdatavalid <= mmio_req.read;
        end
    end

    always_ff @(posedge clk)
    begin
        mmio_rsp.readdata <= rd_data;
    end

endmodule

// ==== hdl/lmx_top.sv ====
// Memory exerciser top level with control, engine, checker and pattern generators
`timescale 1ns/1ps

module lmx_top
(
    input  logic               clk,
    input  logic               rst,
    input  lmx_pkg::t_mmio_req mmio_req,
    input  lmx_pkg::t_mem_rsp  mem_rsp,
    output lmx_pkg::t_mmio_rsp mmio_rsp,
    output lmx_pkg::t_mem_req  mem_req
);

    lmx_pkg::t_run_cfg    cfg;
    lmx_pkg::t_mem_data   seed;
    lmx_pkg::t_mem_data   wr_word;
    lmx_pkg::t_mem_data   chk_word;
    lmx_pkg::t_word_count err_count;
    lmx_pkg::t_mem_addr   first_err_addr;
    logic                 wr_start;
    logic                 rd_start;
    logic                 load_seed;
    logic                 wr_advance;
    logic                 rd_advance;
    logic                 wr_done;
    logic                 rd_done;

    // ==================================================
    // Registers and sequencer
    // ==================================================
    lmx_ctl ctl_i
    (
        .clk            (clk),
        .rst            (rst),
        .mmio_req       (mmio_req),
        .wr_done        (wr_done),
        .rd_done        (rd_done),
        .err_count      (err_count),
        .first_err_addr (first_err_addr),
        .mmio_rsp       (mmio_rsp),
        .cfg            (cfg),
        .seed           (seed),
        .wr_start       (wr_start),
        .rd_start       (rd_start),
        .load_seed      (load_seed)
    );

    // ==================================================
    // Datapath
    // ==================================================
    // Write side pattern steps on accepted writes
    lmx_pattern_gen wr_pat_i
    (
        .clk     (clk),
        .rst     (rst),
        .load    (load_seed),
        .seed    (seed),
        .advance (wr_advance),
        .word    (wr_word)
    );

    // Check side pattern steps on consumed responses
    lmx_pattern_gen chk_pat_i
    (
        .clk     (clk),
        .rst     (rst),
        .load    (load_seed),
        .seed    (seed),
        .advance (rd_advance),
        .word    (chk_word)
    );

    lmx_mem_engine engine_i
    (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .wr_start   (wr_start),
        .rd_start   (rd_start),
        .wr_data    (wr_word),
        .mem_rsp    (mem_rsp),
        .mem_req    (mem_req),
        .wr_advance (wr_advance),
        .wr_done    (wr_done)
    );

    lmx_checker checker_i
    (
        .clk            (clk),
        .rst            (rst),
        .cfg            (cfg),
        .rd_start       (rd_start),
        .mem_rsp        (mem_rsp),
        .expected       (chk_word),
        .rd_advance     (rd_advance),
        .rd_done        (rd_done),
        .err_count      (err_count),
        .first_err_addr (first_err_addr)
    );

endmodule

// ==== tb/lmx_tb.sv ====
// Testbench top with clock, reset, MMIO tasks, run table, checks and result summary
`timescale 1ns/1ps
`include "lmx_config.svh"

module lmx_tb;

    localparam int RAND_SEED  = 80561;
    localparam int POLL_LIMIT = 2000;
    localparam int RSP_LIMIT  = 20;
    localparam int NUM_ROWS   = 5;

    // MMIO register indices
    localparam lmx_pkg::t_mmio_addr REG_ID        = lmx_pkg::t_mmio_addr'(0);
    localparam lmx_pkg::t_mmio_addr REG_CTRL      = lmx_pkg::t_mmio_addr'(1);
    localparam lmx_pkg::t_mmio_addr REG_BASE      = lmx_pkg::t_mmio_addr'(2);
    localparam lmx_pkg::t_mmio_addr REG_COUNT     = lmx_pkg::t_mmio_addr'(3);
    localparam lmx_pkg::t_mmio_addr REG_SEED      = lmx_pkg::t_mmio_addr'(4);
    localparam lmx_pkg::t_mmio_addr REG_STATUS    = lmx_pkg::t_mmio_addr'(5);
    localparam lmx_pkg::t_mmio_addr REG_ERR_COUNT = lmx_pkg::t_mmio_addr'(6);
    localparam lmx_pkg::t_mmio_addr REG_FIRST_ERR = lmx_pkg::t_mmio_addr'(7);

    // One table run
    // corrupt holds a word index or -1 for none
    typedef struct packed {
        logic                 mode;
        lmx_pkg::t_mem_addr   base;
        lmx_pkg::t_word_count count;
        lmx_pkg::t_mem_data   seed;
        int                   corrupt;
        int                   exp_errs;
        int                   wait_pct;
        int                   lat_min;
        int                   lat_max;
    } t_row;

    t_row rows [NUM_ROWS];

    logic                clk;
    logic                rst;
    lmx_pkg::t_mmio_req  mmio_req;
    lmx_pkg::t_mmio_rsp  mmio_rsp;
    lmx_pkg::t_mem_req   mem_req;
    wire lmx_pkg::t_mem_rsp mem_rsp;

    int test_errs    = 0;
    int tests        = 0;
    int tests_failed = 0;
    int checks_failed = 0;

    always #4 clk = ~clk;

    lmx_top dut_i
    (
        .clk      (clk),
        .rst      (rst),
        .mmio_req (mmio_req),
        .mem_rsp  (mem_rsp),
        .mmio_rsp (mmio_rsp),
        .mem_req  (mem_req)
    );

    lmx_mem_model #(.SEED(RAND_SEED)) mem_i
    (
        .clk           (clk),
        .rst           (rst),
        .address       (mem_req.address),
        .read          (mem_req.read),
        .write         (mem_req.write),
        .writedata     (mem_req.writedata),
        .waitrequest   (mem_rsp.waitrequest),
        .readdatavalid (mem_rsp.readdatavalid),
        .readdata      (mem_rsp.readdata)
    );

    // ==================================================
    // Helpers
    // ==================================================
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        checks_failed += test_errs;
        if (test_errs == 0)
        begin
            $display("test %0d %s: passed", tests, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests, name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic abort(input string why);
        $display("ERROR: %s", why);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // Right shifting Galois step for x^64+x^63+x^61+x^60+1
    // Exponent k lands on bit k-1
    function automatic lmx_pkg::t_mem_data lfsr_next(input lmx_pkg::t_mem_data s);
        lmx_pkg::t_mem_data taps;
        taps = (64'd1 << 63) | (64'd1 << 62) | (64'd1 << 60) | (64'd1 << 59);
        return s[0] ? ((s >> 1) ^ taps) : (s >> 1);
    endfunction

    task automatic mmio_write(input lmx_pkg::t_mmio_addr addr, input logic [63:0] data);
        @(posedge clk);
        mmio_req.address   <= addr;
        mmio_req.writedata <= data;
        mmio_req.write     <= 1'b1;
        @(posedge clk);
        mmio_req.write <= 1'b0;
    endtask

    // Response is due one cycle after the read cycle
    task automatic mmio_read(input lmx_pkg::t_mmio_addr addr, output logic [63:0] data);
        int   waited;
        logic got;
        @(posedge clk);
        mmio_req.address <= addr;
        mmio_req.read    <= 1'b1;
        @(posedge clk);
        mmio_req.read <= 1'b0;
        waited = 0;
        got    = 1'b0;
        while (!got && waited < RSP_LIMIT)
        begin
            @(posedge clk);
            waited++;
            got = mmio_rsp.readdatavalid;
        end
        if (!got)
        begin
            abort("MMIO read got no readdatavalid");
        end
        else
        begin
            data = mmio_rsp.readdata;
            check_value("mmio_rsp.readdatavalid delay", 64'(waited), 64'd1);
        end
    endtask

    task automatic program_run(input lmx_pkg::t_mem_addr base,
                               input lmx_pkg::t_word_count count,
                               input lmx_pkg::t_mem_data seed);
        mmio_write(REG_BASE, 64'(base));
        mmio_write(REG_COUNT, 64'(count));
        mmio_write(REG_SEED, seed);
    endtask

    task automatic start_run(input logic mode);
        mmio_write(REG_CTRL, {62'b0, mode, 1'b1});
    endtask

    task automatic wait_done(output logic [63:0] st);
        int polls;
        st    = '0;
        polls = 0;
        while (!st[1] && polls < POLL_LIMIT)
        begin
            mmio_read(REG_STATUS, st);
            polls++;
        end
        if (!st[1])
        begin
            abort("run did not reach done within the poll limit");
        end
    endtask

    // Status, error registers and the read credit bound
    task automatic check_results(input int exp_errs, input lmx_pkg::t_mem_addr exp_first);
        logic [63:0] val;
        mmio_read(REG_STATUS, val);
        check_value("STATUS", val, {61'b0, exp_errs != 0, 1'b1, 1'b0});
        mmio_read(REG_ERR_COUNT, val);
        check_value("ERR_COUNT", val, 64'(exp_errs));
        if (exp_errs != 0)
        begin
            mmio_read(REG_FIRST_ERR, val);
            check_value("FIRST_ERR_ADDR", val, 64'(exp_first));
        end
        assert (mem_i.max_in_flight <= `LMX_MAX_RD_OUTSTANDING)
        else
        begin
            $display("CHECK FAILED: reads in flight got 0x%h limit 0x%h",
                     mem_i.max_in_flight, `LMX_MAX_RD_OUTSTANDING);
            test_errs++;
        end
    endtask

    // Word i of the region is the seed stepped i times
    task automatic check_memory(input lmx_pkg::t_mem_addr base,
                                input lmx_pkg::t_word_count count,
                                input lmx_pkg::t_mem_data seed);
        lmx_pkg::t_mem_data w;
        lmx_pkg::t_mem_addr a;
        w = seed;
        for (int i = 0; i < int'(count); i++)
        begin
            a = base + lmx_pkg::t_mem_addr'(i);
            check_value($sformatf("memory word 0x%h", a), mem_i.peek(a), w);
            w = lfsr_next(w);
        end
    endtask

    task automatic run_row(input t_row r);
        logic [63:0]        st;
        lmx_pkg::t_mem_addr first;
        first = r.base + lmx_pkg::t_mem_addr'(r.corrupt);
        mem_i.set_timing(r.wait_pct, r.lat_min, r.lat_max);
        mem_i.reset_peak();
        if (r.corrupt >= 0)
        begin
            mem_i.corrupt_word(first);
        end
        program_run(r.base, r.count, r.seed);
        start_run(r.mode);
        wait_done(st);
        check_results(r.exp_errs, first);
        if (!r.mode)
        begin
            check_memory(r.base, r.count, r.seed);
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial
    begin
        logic [63:0] val;
        clk      = 1'b0;
        rst      = 1'b1;
        mmio_req = '0;

        // mode, base, count, seed, corrupt, errors, wait %, latency min, max
        rows[0] = '{1'b0, 12'h100, 13'd64, 64'h0123_4567_89AB_CDEF, -1, 0, 30, 1, 4};
        // Same region read back after one word is damaged
        rows[1] = '{1'b1, 12'h100, 13'd64, 64'h0123_4567_89AB_CDEF, 17, 1, 20, 1, 6};
        rows[2] = '{1'b0, 12'h7F0, 13'd1, 64'hFEDC_BA98_7654_3210, -1, 0, 25, 1, 3};
        // Long latency keeps the credit limit busy
        rows[3] = '{1'b0, 12'h200, 13'd40, 64'h0000_0000_0000_0001, -1, 0, 10, 20, 30};
        rows[4] = '{1'b0, 12'h000, 13'd16, 64'h0, -1, 0, 50, 2, 8};

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Reset state
        mmio_read(REG_ID, val);
        check_value("ID", val, `LMX_ID_VALUE);
        mmio_read(REG_STATUS, val);
        check_value("STATUS", val, 64'h0);
        check_value("mem_req.read", 64'(mem_req.read), 64'h0);
        check_value("mem_req.write", 64'(mem_req.write), 64'h0);
        check_value("model request count", 64'(mem_i.rd_count + mem_i.wr_count), 64'h0);
        finish_test("reset state");

        // Register readback without the start bit
        mmio_write(REG_BASE, 64'hABC);
        mmio_write(REG_COUNT, 64'h1234);
        mmio_write(REG_SEED, 64'hDEAD_BEEF_0BAD_F00D);
        mmio_write(REG_CTRL, 64'h2);
        mmio_read(REG_BASE, val);
        check_value("BASE", val, 64'hABC);
        mmio_read(REG_COUNT, val);
        check_value("COUNT", val, 64'h1234);
        mmio_read(REG_SEED, val);
        check_value("SEED", val, 64'hDEAD_BEEF_0BAD_F00D);
        mmio_read(REG_CTRL, val);
        check_value("CTRL", val, 64'h2);
        mmio_write(REG_CTRL, 64'h0);
        mmio_read(REG_CTRL, val);
        check_value("CTRL", val, 64'h0);
        check_value("model request count", 64'(mem_i.rd_count + mem_i.wr_count), 64'h0);
        finish_test("register readback");

        for (int i = 0; i < NUM_ROWS; i++)
        begin
            run_row(rows[i]);
            finish_test($sformatf("table row %0d", i));
        end

        // Start while busy is dropped
        mem_i.set_timing(20, 15, 25);
        mem_i.reset_peak();
        program_run(12'h300, 13'd48, 64'h5555_AAAA_1234_5678);
        start_run(1'b0);
        mmio_read(REG_STATUS, val);
        check_value("STATUS", val, 64'h1);
        start_run(1'b1);
        wait_done(val);
        check_results(0, '0);
        check_memory(12'h300, 13'd48, 64'h5555_AAAA_1234_5678);
        // Damaged word seen by a read-only run
        mem_i.corrupt_word(12'h305);
        start_run(1'b1);
        wait_done(val);
        check_results(1, 12'h305);
        // New start clears done and the error count
        start_run(1'b0);
        mmio_read(REG_STATUS, val);
        check_value("STATUS", val, 64'h1);
        mmio_read(REG_ERR_COUNT, val);
        check_value("ERR_COUNT", val, 64'h0);
        wait_done(val);
        check_results(0, '0);
        finish_test("start while busy");

        $display("tests %0d, passed %0d, failed %0d, failed checks %0d",
                 tests, tests - tests_failed, tests_failed, checks_failed);
        if (tests_failed == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
tb/lmx_mem_model.sv
hdl/lmx_pkg.sv
hdl/lmx_pattern_gen.sv
hdl/lmx_mem_engine.sv
hdl/lmx_checker.sv
hdl/lmx_ctl.sv
hdl/lmx_top.sv
tb/lmx_tb.sv

// ==== Bender.yml ====
package:
  name: lmx

sources:
  - include_dirs:
      - include
    files:
      - tb/lmx_mem_model.sv
      - hdl/lmx_pkg.sv
      - hdl/lmx_pattern_gen.sv
      - hdl/lmx_mem_engine.sv
      - hdl/lmx_checker.sv
      - hdl/lmx_ctl.sv
      - hdl/lmx_top.sv
      - tb/lmx_tb.sv
